/* rtl/team_01_pkg.sv */
// Keypad entry tile shared definitions
// Bus and LCD widths, key codes, controller states and HD44780 commands
`default_nettype none

package team_01_pkg;

   // Wishbone address or data word
   typedef logic [31:0] word_t;

   // Wishbone byte lane select
   typedef logic [3:0] sel_t;

   // Keypad code, 0 to 13 are hex digits 0 to D
   typedef logic [3:0] key_t;

   // Byte sent to the LCD, data or command
   typedef logic [7:0] lcd_byte_t;

   // Non-digit keys
   localparam key_t KEY_STAR = 4'd14;
   localparam key_t KEY_HASH = 4'd15;

   // Controller FSM
   typedef enum logic [2:0] {
      INIT,
      IDLE,
      SHOW_DIGIT,
      CLEAR,
      BUS_WRITE,
      BUS_READ,
      SET_LINE2,
      SHOW_HEX
   } cpu_state_t;

   // 8-bit bus, two lines, 5x8 font
   localparam lcd_byte_t LCD_FUNC_SET = 8'h38;
   // Display on, cursor off, no blink
   localparam lcd_byte_t LCD_DISP_ON  = 8'h0C;
   // Clear display and home cursor
   localparam lcd_byte_t LCD_CLEAR    = 8'h01;
   // DDRAM address 0x40, start of line 2
   localparam lcd_byte_t LCD_LINE2    = 8'hC0;

endpackage

`default_nettype wire

/* rtl/wb_req_if.sv */
// Wishbone request bundle
// Single read or write requests from the controller to the bus manager
`default_nettype none

interface wb_req_if;
   import team_01_pkg::*;

   word_t adr;
   word_t wdata;
   sel_t  sel;
   // One-cycle request pulses, only while busy is low
   logic  write;
   logic  read;
   // Valid once busy drops after a read
   word_t rdata;
   logic  busy;

   modport host (output adr, wdata, sel, write, read, input rdata, busy);

   modport manager (input adr, wdata, sel, write, read, output rdata, busy);

endinterface

`default_nettype wire

/* rtl/lcd_req_if.sv */
// LCD request bundle
// One byte per strobe from the controller to the LCD writer
`default_nettype none

interface lcd_req_if;
   import team_01_pkg::*;

   lcd_byte_t data;
   // High for character data, low for commands
   logic      rs;
   logic      strobe;
   logic      busy;

   modport host (output data, rs, strobe, input busy);

   modport writer (input data, rs, strobe, output busy);

endinterface

`default_nettype wire

/* rtl/wishbone_manager.sv */
// Wishbone classic manager
// Turns one-cycle read or write requests into single bus cycles,
// holds the cycle open until ACK and returns the read data
`default_nettype none

module wishbone_manager (
   input  logic                clk,
   input  logic                rst_n_i,
   wb_req_if.manager           wb,
   input  team_01_pkg::word_t  wb_dat_i,
   input  logic                wb_ack_i,
   output team_01_pkg::word_t  wb_adr_o,
   output team_01_pkg::word_t  wb_dat_o,
   output team_01_pkg::sel_t   wb_sel_o,
   output logic                wb_we_o,
   output logic                wb_stb_o,
   output logic                wb_cyc_o
);

   typedef enum logic {
      WB_IDLE,
      WB_BUSY
   } wb_state_t;

   wb_state_t state;
   logic      req;

   // Either request starts a cycle
   assign req = wb.write || wb.read;

   // Busy from the cycle after the request until the cycle after ACK
   assign wb.busy = (state == WB_BUSY);

   // Cycle control
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state    <= WB_IDLE;
         wb_cyc_o <= 1'b0;
         wb_stb_o <= 1'b0;
         wb_we_o  <= 1'b0;
      end else begin
         case (state)
            WB_IDLE: begin
               if (req) begin
                  state    <= WB_BUSY;
                  wb_cyc_o <= 1'b1;
                  wb_stb_o <= 1'b1;
                  wb_we_o  <= wb.write;
               end
            end
            WB_BUSY: begin
               // Slave sets the latency
               if (wb_ack_i) begin
                  state    <= WB_IDLE;
                  wb_cyc_o <= 1'b0;
                  wb_stb_o <= 1'b0;
                  wb_we_o  <= 1'b0;
               end
            end
            default: state <= WB_IDLE;
         endcase
      end
   end

   // Address, data and select held for the whole cycle
   always_ff @(posedge clk) begin
      if (state == WB_IDLE && req) begin
         wb_adr_o <= wb.adr;
         wb_dat_o <= wb.wdata;
         wb_sel_o <= wb.sel;
      end
   end

   // Read data taken on the ACK edge
   always_ff @(posedge clk) begin
      if (state == WB_BUSY && wb_ack_i && !wb_we_o) begin
         wb.rdata <= wb_dat_i;
      end
   end

endmodule

`default_nettype wire

/* rtl/keypad_scanner.sv */
// 4x4 matrix keypad scanner
// Rotates one high column, samples the rows, debounces over two scans
// and reports each press once
`default_nettype none

module keypad_scanner #(
   parameter int SCAN_CYCLES = 1000
) (
   input  logic               clk,
   input  logic               rst_n_i,
   input  logic [3:0]         rows_i,
   output logic [3:0]         cols_o,
   output team_01_pkg::key_t  key_o,
   output logic               key_valid_o
);
   import team_01_pkg::*;

   // SCAN_CYCLES of 3 or more covers the row sync delay
   localparam int            DW         = $clog2(SCAN_CYCLES + 1);
   localparam logic [DW-1:0] DWELL_LAST = DW'(SCAN_CYCLES - 1);

   // Code per {row, col}, phone layout with * and # on the bottom row
   localparam key_t KEY_MAP [16] = '{
      4'h1,     4'h2, 4'h3,     4'hA,
      4'h4,     4'h5, 4'h6,     4'hB,
      4'h7,     4'h8, 4'h9,     4'hC,
      KEY_STAR, 4'h0, KEY_HASH, 4'hD
   };

   logic [3:0]    rows_meta;
   logic [3:0]    rows_sync;
   logic [1:0]    col_idx;
   logic [DW-1:0] dwell;
   logic          dwell_end;
   logic          scan_end;
   logic          row_hit;
   logic [1:0]    row_idx;
   key_t          col_key;
   logic          found;
   key_t          found_key;
   logic          scan_hit;
   key_t          scan_key;
   logic          prev_hit;
   key_t          prev_key;
   logic          reported;

   // Rows come from pins
   always_ff @(posedge clk) begin
      rows_meta <= rows_i;
      rows_sync <= rows_meta;
   end

   assign cols_o    = 4'b0001 << col_idx;
   assign dwell_end = (dwell == DWELL_LAST);
   assign scan_end  = dwell_end && (col_idx == 2'd3);

   // Lowest pressed row wins
   always_comb begin
      row_hit = |rows_sync;
      row_idx = 2'd0;
      for (int r = 3; r >= 0; r--) begin
         if (rows_sync[r]) begin
            row_idx = 2'(r);
         end
      end
   end

   assign col_key = KEY_MAP[{row_idx, col_idx}];

   // Result of the scan ending now, first column hit kept
   assign scan_hit = found || row_hit;
   assign scan_key = found ? found_key : col_key;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         col_idx     <= 2'd0;
         dwell       <= '0;
         found       <= 1'b0;
         prev_hit    <= 1'b0;
         reported    <= 1'b0;
         key_valid_o <= 1'b0;
      end else begin
         key_valid_o <= 1'b0;
         if (!dwell_end) begin
            dwell <= dwell + 1'b1;
         end else begin
            dwell   <= '0;
            col_idx <= col_idx + 2'd1;
            if (scan_end) begin
               found    <= 1'b0;
               prev_hit <= scan_hit;
               // Release re-arms the next report
               if (!scan_hit) begin
                  reported <= 1'b0;
               end else if (prev_hit && scan_key == prev_key && !reported) begin
                  key_valid_o <= 1'b1;
                  reported    <= 1'b1;
               end
            end else if (row_hit && !found) begin
               found <= 1'b1;
            end
         end
      end
   end

   // Key codes
   always_ff @(posedge clk) begin
      if (dwell_end && row_hit && !found) begin
         found_key <= col_key;
      end
      if (scan_end) begin
         prev_key <= scan_key;
         key_o    <= scan_key;
      end
   end

endmodule

`default_nettype wire

/* rtl/lcd_writer.sv */
// HD44780 byte writer, 8-bit mode
// Holds RS and data, drives the enable pulse and waits out the settle gap
`default_nettype none

module lcd_writer #(
   parameter int LCD_EN_CYCLES  = 8,
   parameter int LCD_GAP_CYCLES = 400
) (
   input  logic                    clk,
   input  logic                    rst_n_i,
   lcd_req_if.writer               lcd,
   output logic                    lcd_en_o,
   output logic                    lcd_rs_o,
   output team_01_pkg::lcd_byte_t  lcd_data_o
);

   localparam int CNT_MAX = (LCD_EN_CYCLES > LCD_GAP_CYCLES) ? LCD_EN_CYCLES
                                                              : LCD_GAP_CYCLES;
   localparam int            CW       = $clog2(CNT_MAX + 1);
   localparam logic [CW-1:0] EN_LAST  = CW'(LCD_EN_CYCLES - 1);
   localparam logic [CW-1:0] GAP_LAST = CW'(LCD_GAP_CYCLES - 1);

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_PULSE,
      PH_GAP
   } phase_t;

   phase_t        phase;
   logic [CW-1:0] cnt;

   // Busy through pulse and gap
   assign lcd.busy = (phase != PH_IDLE);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         phase    <= PH_IDLE;
         cnt      <= '0;
         lcd_en_o <= 1'b0;
      end else begin
         case (phase)
            PH_IDLE: begin
               if (lcd.strobe) begin
                  phase    <= PH_PULSE;
                  cnt      <= '0;
                  lcd_en_o <= 1'b1;
               end
            end
            PH_PULSE: begin
               // Enable high for exactly LCD_EN_CYCLES
               if (cnt == EN_LAST) begin
                  phase    <= PH_GAP;
                  cnt      <= '0;
                  lcd_en_o <= 1'b0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            PH_GAP: begin
               // Controller settle time
               if (cnt == GAP_LAST) begin
                  phase <= PH_IDLE;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: phase <= PH_IDLE;
         endcase
      end
   end

   // Byte latched on strobe, held until the next one
   always_ff @(posedge clk) begin
      if (phase == PH_IDLE && lcd.strobe) begin
         lcd_rs_o   <= lcd.rs;
         lcd_data_o <= lcd.data;
      end
   end

endmodule

`default_nettype wire

/* rtl/team_01_cpu.sv */
// Keypad entry controller
// LCD init, digit echo and entry shift, clear, and the
// write, readback and hex print sequence on '#'
`default_nettype none

module team_01_cpu #(
   parameter team_01_pkg::word_t RESULT_ADDR = 32'h3000_0000
) (
   input  logic               clk,
   input  logic               rst_n_i,
   input  logic               en_i,
   input  team_01_pkg::key_t  key_i,
   input  logic               key_valid_i,
   wb_req_if.host             wb,
   lcd_req_if.host            lcd
);
   import team_01_pkg::*;

   cpu_state_t state;
   word_t      entry;
   word_t      readback;
   logic [2:0] nib_cnt;
   logic       pending;
   logic       on_bus;
   logic       unit_busy;
   logic       issue;
   logic       done;
   lcd_byte_t  init_cmd;

   // Uppercase ASCII hex
   function automatic lcd_byte_t hex_ascii(input logic [3:0] nib);
      if (nib < 4'd10) begin
         return 8'h30 + {4'h0, nib};
      end
      return 8'h37 + {4'h0, nib};
   endfunction

   // Each state issues one request, then waits for the unit to go idle
   assign on_bus    = (state == BUS_WRITE) || (state == BUS_READ);
   assign unit_busy = on_bus ? wb.busy : lcd.busy;
   assign issue     = (state != IDLE) && !pending && !unit_busy;
   assign done      = pending && !unit_busy;

   // Single word at a fixed address, all lanes
   assign wb.adr   = RESULT_ADDR;
   assign wb.wdata = entry;
   assign wb.sel   = '1;
   assign wb.write = issue && (state == BUS_WRITE);
   assign wb.read  = issue && (state == BUS_READ);

   assign lcd.strobe = issue && !on_bus;

   // LCD byte per state
   always_comb begin
      case (nib_cnt)
         3'd0:    init_cmd = LCD_FUNC_SET;
         3'd1:    init_cmd = LCD_DISP_ON;
         default: init_cmd = LCD_CLEAR;
      endcase
      lcd.rs   = 1'b0;
      lcd.data = init_cmd;
      case (state)
         SHOW_DIGIT: begin
            lcd.rs   = 1'b1;
            lcd.data = hex_ascii(entry[3:0]);
         end
         CLEAR:     lcd.data = LCD_CLEAR;
         SET_LINE2: lcd.data = LCD_LINE2;
         SHOW_HEX: begin
            lcd.rs   = 1'b1;
            lcd.data = hex_ascii(readback[31:28]);
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state   <= INIT;
         pending <= 1'b0;
         nib_cnt <= 3'd0;
         entry   <= '0;
      end else begin
         if (issue) begin
            pending <= 1'b1;
         end else if (done) begin
            pending <= 1'b0;
         end
         case (state)
            INIT: begin
               // Three init commands, counted by nib_cnt
               if (done) begin
                  if (nib_cnt == 3'd2) begin
                     nib_cnt <= 3'd0;
                     state   <= IDLE;
                  end else begin
                     nib_cnt <= nib_cnt + 3'd1;
                  end
               end
            end
            IDLE: begin
               // Keys outside IDLE are dropped
               if (key_valid_i && en_i) begin
                  if (key_i == KEY_STAR) begin
                     entry <= '0;
                     state <= CLEAR;
                  end else if (key_i == KEY_HASH) begin
                     state <= BUS_WRITE;
                  end else begin
                     entry <= {entry[27:0], key_i};
                     state <= SHOW_DIGIT;
                  end
               end
            end
            SHOW_DIGIT, CLEAR: if (done) state <= IDLE;
            BUS_WRITE:         if (done) state <= BUS_READ;
            BUS_READ:          if (done) state <= SET_LINE2;
            SET_LINE2:         if (done) state <= SHOW_HEX;
            SHOW_HEX: begin
               // Eight characters, top nibble first
               if (done) begin
                  if (nib_cnt == 3'd7) begin
                     nib_cnt <= 3'd0;
                     state   <= IDLE;
                  end else begin
                     nib_cnt <= nib_cnt + 3'd1;
                  end
               end
            end
            default: state <= INIT;
         endcase
      end
   end

   // Readback word, shifted up one nibble per printed char
   always_ff @(posedge clk) begin
      if (state == BUS_READ && done) begin
         readback <= wb.rdata;
      end else if (state == SHOW_HEX && done) begin
         readback <= {readback[27:0], 4'h0};
      end
   end

endmodule

`default_nettype wire

/* rtl/team_01.sv */
// Keypad entry tile top
// Keypad scanner, controller, Wishbone manager and LCD writer on GPIO
`default_nettype none

module team_01 #(
   parameter int                 SCAN_CYCLES    = 200,
   parameter int                 LCD_EN_CYCLES  = 4,
   parameter int                 LCD_GAP_CYCLES = 40,
   parameter team_01_pkg::word_t RESULT_ADDR    = 32'h3000_0100
) (
   input  logic                clk,
   input  logic                rst_n_i,
   // Chip enable, low blocks new key handling
   input  logic                en_i,
   input  logic [127:0]        la_data_i,
   output logic [127:0]        la_data_o,
   input  logic [127:0]        la_oenb_i,
   input  logic [33:0]         gpio_i,
   output logic [33:0]         gpio_o,
   output logic [33:0]         gpio_oeb_o,
   input  team_01_pkg::word_t  wb_dat_i,
   input  logic                wb_ack_i,
   output team_01_pkg::word_t  wb_adr_o,
   output team_01_pkg::word_t  wb_dat_o,
   output team_01_pkg::sel_t   wb_sel_o,
   output logic                wb_we_o,
   output logic                wb_stb_o,
   output logic                wb_cyc_o
);
   import team_01_pkg::*;

   key_t       key;
   logic       key_valid;
   logic [3:0] cols;
   logic       lcd_en;
   logic       lcd_rs;
   lcd_byte_t  lcd_data;

   wb_req_if  wb_req ();
   lcd_req_if lcd_req ();

   keypad_scanner #(
      .SCAN_CYCLES (SCAN_CYCLES)
   ) keypad (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .rows_i      (gpio_i[19:16]),
      .cols_o      (cols),
      .key_o       (key),
      .key_valid_o (key_valid)
   );

   team_01_cpu #(
      .RESULT_ADDR (RESULT_ADDR)
   ) cpu (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .en_i        (en_i),
      .key_i       (key),
      .key_valid_i (key_valid),
      .wb          (wb_req.host),
      .lcd         (lcd_req.host)
   );

   wishbone_manager wbm (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb       (wb_req.manager),
      .wb_dat_i (wb_dat_i),
      .wb_ack_i (wb_ack_i),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_sel_o (wb_sel_o),
      .wb_we_o  (wb_we_o),
      .wb_stb_o (wb_stb_o),
      .wb_cyc_o (wb_cyc_o)
   );

   lcd_writer #(
      .LCD_EN_CYCLES  (LCD_EN_CYCLES),
      .LCD_GAP_CYCLES (LCD_GAP_CYCLES)
   ) lcdw (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .lcd        (lcd_req.writer),
      .lcd_en_o   (lcd_en),
      .lcd_rs_o   (lcd_rs),
      .lcd_data_o (lcd_data)
   );

   // Logic analyzer unused
   assign la_data_o = '0;

   // Pins: cols 23:20, rows 19:16, data 15:8, rw 7 low, rs 6, en 5
   assign gpio_o = {10'b0, cols, 4'b0, lcd_data, 1'b0, lcd_rs, lcd_en, 5'b0};

   // Only the row pins are inputs
   assign gpio_oeb_o = {10'b0, 4'b0, 4'b1111, 8'b0, 3'b0, 5'b0};

endmodule

`default_nettype wire

/* dv/tb_team_01.sv */
// Keypad entry tile testbench
// Keypad model, Wishbone memory with random ACK delay, LCD monitor,
// and key sequences with expected results from the golden file
`default_nettype none

module tb_team_01;
   timeunit 1ns;
   timeprecision 100ps;
   import team_01_pkg::*;

   localparam word_t RESULT_ADDR = 32'h3000_0100;
   localparam int    SCAN_CYCLES = 8;
   // One full keypad scan, four columns
   localparam int    SCAN_LEN    = 4 * SCAN_CYCLES;
   localparam int    HOLD_SCANS  = 4;
   localparam int    LCD_TIMEOUT = 20 * SCAN_LEN;

   // GPIO outputs tied low on bits 33:24, 19:16, 7 and 4:0
   localparam logic [33:0] GPIO_TIED = {10'h3FF, 4'h0, 4'hF, 8'h00, 1'b1, 2'b00, 5'h1F};
   // Output enable high only on the keypad rows
   localparam logic [33:0] GPIO_OEB  = {10'h000, 4'h0, 4'hF, 8'h00, 8'h00};

   logic           clk = 1'b0;
   logic           rst_n_i;
   logic           en_i;
   logic [127:0]   la_data_i;
   logic [127:0]   la_data_o;
   logic [127:0]   la_oenb_i;
   logic [33:0]    gpio_i;
   logic [33:0]    gpio_o;
   logic [33:0]    gpio_oeb_o;
   word_t          wb_dat_i = '0;
   logic           wb_ack_i = 1'b0;
   word_t          wb_adr_o;
   word_t          wb_dat_o;
   sel_t           wb_sel_o;
   logic           wb_we_o;
   logic           wb_stb_o;
   logic           wb_cyc_o;

   // Keypad model state
   logic           pressed;
   logic [1:0]     key_row;
   logic [1:0]     key_col;
   logic [3:0]     rows;

   // Recorded LCD bytes and bus cycles
   lcd_byte_t      lcd_data_q[$];
   logic           lcd_rs_q[$];
   logic           prev_en = 1'b0;
   logic           bus_we_q[$];
   word_t          bus_adr_q[$];
   word_t          bus_dat_q[$];
   sel_t           bus_sel_q[$];
   word_t          mem[word_t];

   int unsigned    lcg_state = 65;
   int             errors = 0;
   int             pass_cnt = 0;
   int             fail_cnt = 0;
   logic           aborted = 1'b0;

   team_01 #(
      .SCAN_CYCLES    (SCAN_CYCLES),
      .LCD_EN_CYCLES  (4),
      .LCD_GAP_CYCLES (12),
      .RESULT_ADDR    (RESULT_ADDR)
   ) DUT (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .en_i       (en_i),
      .la_data_i  (la_data_i),
      .la_data_o  (la_data_o),
      .la_oenb_i  (la_oenb_i),
      .gpio_i     (gpio_i),
      .gpio_o     (gpio_o),
      .gpio_oeb_o (gpio_oeb_o),
      .wb_dat_i   (wb_dat_i),
      .wb_ack_i   (wb_ack_i),
      .wb_adr_o   (wb_adr_o),
      .wb_dat_o   (wb_dat_o),
      .wb_sel_o   (wb_sel_o),
      .wb_we_o    (wb_we_o),
      .wb_stb_o   (wb_stb_o),
      .wb_cyc_o   (wb_cyc_o)
   );

   always #50 clk = ~clk;

   // Pressed key closes its row onto its column
   always_comb begin
      rows = 4'b0;
      if (pressed && gpio_o[23:20] == (4'b0001 << key_col)) begin
         rows[key_row] = 1'b1;
      end
   end
   assign gpio_i = {14'b0, rows, 16'b0};

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   // LCD monitor, en on gpio 5, rs on 6, data on 15:8
   always @(posedge clk) begin
      if (gpio_o[5] && !prev_en) begin
         lcd_data_q.push_back(gpio_o[15:8]);
         lcd_rs_q.push_back(gpio_o[6]);
      end
      prev_en <= gpio_o[5];
   end

   // Wishbone memory, ACK 1 to 4 cycles after the cycle is seen
   always begin : memory_model
      int unsigned ack_delay;
      @(posedge clk);
      if (wb_cyc_o && wb_stb_o) begin
         bus_we_q.push_back(wb_we_o);
         bus_adr_q.push_back(wb_adr_o);
         bus_dat_q.push_back(wb_dat_o);
         bus_sel_q.push_back(wb_sel_o);
         ack_delay = 1 + lcg_next() % 4;
         repeat (ack_delay - 1) @(posedge clk);
         #10;
         if (wb_we_o) begin
            mem[wb_adr_o] = wb_dat_o;
         end else begin
            wb_dat_i = mem.exists(wb_adr_o) ? mem[wb_adr_o] : '0;
         end
         wb_ack_i = 1'b1;
         @(posedge clk);
         #10;
         wb_ack_i = 1'b0;
      end
   end

   task automatic step(input int n);
      repeat (n) @(posedge clk);
      #10;
   endtask

   task automatic check_word(input string what, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("[FAIL] %s expected %08h actual %08h", what, exp, act);
         errors++;
      end
   endtask

   task automatic check_lcd(input string what, input lcd_byte_t exp, input logic exp_rs,
                            input lcd_byte_t act, input logic act_rs);
      if (act !== exp || act_rs !== exp_rs) begin
         $display("[FAIL] %s expected rs=%0b %02h actual rs=%0b %02h",
                  what, exp_rs, exp, act_rs, act);
         errors++;
      end
   endtask

   task automatic check_gpio(input string what, input logic [33:0] exp,
                             input logic [33:0] act);
      if (act !== exp) begin
         $display("[FAIL] %s expected %09h actual %09h", what, exp, act);
         errors++;
      end
   endtask

   task automatic check_la(input string what, input logic [127:0] exp,
                           input logic [127:0] act);
      if (act !== exp) begin
         $display("[FAIL] %s expected %032h actual %032h", what, exp, act);
         errors++;
      end
   endtask

   // Wait for the LCD monitor to hold count bytes in total
   task automatic wait_lcd(input int count, input string name);
      int cycles;
      cycles = 0;
      while (lcd_data_q.size() < count && cycles < LCD_TIMEOUT) begin
         step(1);
         cycles++;
      end
      if (lcd_data_q.size() < count) begin
         $display("%s: timeout waiting for LCD byte %0d, only %0d arrived",
                  name, count, lcd_data_q.size());
         aborted = 1'b1;
      end
   endtask

   // Physical layout, row by row
   task automatic press_key(input byte k);
      string layout;
      int    pos;
      layout = "123A456B789C*0#D";
      pos = -1;
      for (int i = 0; i < 16; i++) begin
         if (layout[i] == k) begin
            pos = i;
         end
      end
      if (pos < 0) begin
         $display("golden file holds unknown key '%c'", k);
         errors++;
      end else begin
         key_row = 2'(pos / 4);
         key_col = 2'(pos % 4);
         pressed = 1'b1;
         step(HOLD_SCANS * SCAN_LEN);
         pressed = 1'b0;
         step(HOLD_SCANS * SCAN_LEN);
      end
   endtask

   task automatic finish_test(input string name, input int start_err);
      if (errors == start_err && !aborted) begin
         $display("%-10s ok", name);
         pass_cnt++;
      end else begin
         $display("%-10s %0d errors", name, errors - start_err);
         fail_cnt++;
      end
   endtask

   task automatic run_test(input string name, input string keys, input string wr,
                           input string l2);
      int        lcd_start;
      int        bus_start;
      int        start_err;
      word_t     exp_word;
      lcd_byte_t exp_data[$];
      logic      exp_rs[$];
      lcd_start = lcd_data_q.size();
      bus_start = bus_we_q.size();
      start_err = errors;
      for (int i = 0; i < keys.len() && !aborted; i++) begin
         if (keys[i] == "-") begin
            en_i = 1'b0;
         end else if (keys[i] == "+") begin
            en_i = 1'b1;
         end else begin
            // Expected LCD traffic only while enabled
            if (en_i && keys[i] == "*") begin
               exp_data.push_back(LCD_CLEAR);
               exp_rs.push_back(1'b0);
            end else if (en_i && keys[i] == "#") begin
               exp_data.push_back(LCD_LINE2);
               exp_rs.push_back(1'b0);
               for (int k = 0; k < 8; k++) begin
                  exp_data.push_back(l2[k]);
                  exp_rs.push_back(1'b1);
               end
            end else if (en_i) begin
               exp_data.push_back(keys[i]);
               exp_rs.push_back(1'b1);
            end
            press_key(keys[i]);
            if (en_i) begin
               wait_lcd(lcd_start + exp_data.size(), name);
            end
         end
      end
      // Quiet window catches extra traffic
      step(2 * SCAN_LEN);
      if (!aborted) begin
         if (lcd_data_q.size() - lcd_start != exp_data.size()) begin
            $display("%s: expected %0d LCD bytes but saw %0d", name, exp_data.size(),
                     lcd_data_q.size() - lcd_start);
            errors++;
         end else begin
            for (int k = 0; k < exp_data.size(); k++) begin
               check_lcd($sformatf("%s lcd byte %0d", name, k), exp_data[k], exp_rs[k],
                         lcd_data_q[lcd_start + k], lcd_rs_q[lcd_start + k]);
            end
         end
         if (wr == "none") begin
            if (bus_we_q.size() != bus_start) begin
               $display("%s: bus cycle seen where none was expected", name);
               errors++;
            end
         end else if (bus_we_q.size() - bus_start != 2 || bus_we_q[bus_start] !== 1'b1 ||
                      bus_we_q[bus_start + 1] !== 1'b0) begin
            $display("%s: expected one write followed by one read on the bus", name);
            errors++;
         end else begin
            void'($sscanf(wr, "%h", exp_word));
            check_word({name, " write adr"}, RESULT_ADDR, bus_adr_q[bus_start]);
            check_word({name, " write data"}, exp_word, bus_dat_q[bus_start]);
            check_word({name, " write sel"}, 32'hF, {28'b0, bus_sel_q[bus_start]});
            check_word({name, " read adr"}, RESULT_ADDR, bus_adr_q[bus_start + 1]);
         end
      end
      finish_test(name, start_err);
   endtask

   initial begin : main
      int    fd;
      int    start_err;
      string line;
      string name;
      string keys;
      string wr;
      string l2;
      rst_n_i   = 1'b0;
      en_i      = 1'b1;
      la_data_i = '0;
      la_oenb_i = '0;
      pressed   = 1'b0;
      key_row   = 2'd0;
      key_col   = 2'd0;
      step(4);
      rst_n_i = 1'b1;

      // Init commands after reset, bus quiet
      start_err = errors;
      if (wb_cyc_o !== 1'b0 || wb_stb_o !== 1'b0 || wb_we_o !== 1'b0) begin
         $display("init: CYC, STB or WE not low after reset");
         errors++;
      end
      // Tied pins and output enables from the GPIO map
      check_gpio("init tied gpio", '0, gpio_o & GPIO_TIED);
      check_gpio("init gpio oeb", GPIO_OEB, gpio_oeb_o);
      check_la("init la data", '0, la_data_o);
      wait_lcd(3, "init");
      step(SCAN_LEN);
      if (!aborted) begin
         check_lcd("init cmd 0", LCD_FUNC_SET, 1'b0, lcd_data_q[0], lcd_rs_q[0]);
         check_lcd("init cmd 1", LCD_DISP_ON, 1'b0, lcd_data_q[1], lcd_rs_q[1]);
         check_lcd("init cmd 2", LCD_CLEAR, 1'b0, lcd_data_q[2], lcd_rs_q[2]);
         if (bus_we_q.size() != 0 || lcd_data_q.size() != 3) begin
            $display("init: unexpected bus cycle or extra LCD byte");
            errors++;
         end
      end
      finish_test("init", start_err);

      fd = $fopen("dv/team_01_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open dv/team_01_golden.txt");
         aborted = 1'b1;
      end else begin
         while (!aborted && $fgets(line, fd) != 0) begin
            // Comment and blank lines skipped
            if (line.substr(0, 1) != "//" &&
                $sscanf(line, "%s %s %s %s", name, keys, wr, l2) == 4) begin
               run_test(name, keys, wr, l2);
            end
         end
         $fclose(fd);
      end

      $display("%0d tests, %0d passed, %0d failed, %0d check errors",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt, errors);
      if (fail_cnt == 0 && errors == 0 && !aborted && pass_cnt > 1) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dv/team_01_golden.txt */
// name  keys  write word in hex or none  LCD line 2 text or none
// keys: 0-9 A-D digits, * clear, # send, - drops en_i, + raises en_i
// The entry carries over from one line to the next

// Digit echo only, entry becomes 00000123
digits    123               none      none

// Two more digits, then send
send      45#               00012345  00012345

// Clear, letters, send
letters   *ABCD09#          00ABCD09  00ABCD09

// More than eight digits keeps the last eight
wrap      *1234567890AB#    567890AB  567890AB

// Clear then send writes zero
clear     *#                00000000  00000000

// Keys ignored while disabled, entry stays zero
disabled  -37#*+            none      none

// Entry still zero before this digit
resume    D#                0000000D  0000000D

// Nine digits
full      *DDDDDDDDC#       DDDDDDDC  DDDDDDDC

// Send again without new digits
repeat    #                 DDDDDDDC  DDDDDDDC

// All digit classes in one word
mixed     *0A1B2C3D#        0A1B2C3D  0A1B2C3D

/* sources.f */
rtl/team_01_pkg.sv
rtl/wb_req_if.sv
rtl/lcd_req_if.sv
rtl/wishbone_manager.sv
rtl/keypad_scanner.sv
rtl/lcd_writer.sv
rtl/team_01_cpu.sv
rtl/team_01.sv
dv/tb_team_01.sv

/* Makefile */
# Verilator build for the keypad entry tile

TOP = tb_team_01

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f sources.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
